/* build.f */
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_decoder.sv
verilog/rv_control.sv
verilog/rv_apb_master.sv
verilog/rv_core.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f build.f -o tb_rv_core \
    && ./obj_dir/tb_rv_core \
    || { echo "simulation failed"; exit 1; }

/* sim/rv_core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties import rv_pkg::*; (
    input logic     clock,
    input logic     reset,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     halted
);

    logic setup;     // First cycle of a transfer
    logic waiting;   // Access cycle stalled by the slave

    assign setup   = apb_req.psel && !apb_req.penable;
    assign waiting = apb_req.psel && apb_req.penable && !apb_rsp.pready;

    penable_needs_psel: assert property (@(posedge clock) disable iff (reset)
        apb_req.penable |-> apb_req.psel)
        else $error("penable high without psel");

    setup_then_access: assert property (@(posedge clock) disable iff (reset)
        setup |=> apb_req.psel && apb_req.penable)
        else $error("setup cycle not followed by access cycle");

    // Address, direction and data frozen until pready ends the access
    fields_stable: assert property (@(posedge clock) disable iff (reset)
        (setup || waiting) |=> $stable(apb_req.paddr) && $stable(apb_req.pwrite)
                               && $stable(apb_req.pwdata))
        else $error("APB fields changed during a transfer");

    psel_low_in_reset: assert property (@(posedge clock) reset |-> !apb_req.psel)
        else $error("psel high during reset");

    halt_is_sticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind rv_core rv_core_properties properties_i (
    .clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp), .halted(halted)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    logic        clock;
    logic        reset;
    apb_rsp_t    apb_rsp;
    apb_req_t    apb_req;
    logic        halted;
    logic [31:0] mem [256];   // Word memory covering byte addresses 0 to 0x3fc
    logic [31:0] lcg_state;
    int          emit_idx;    // Next program word
    int          waits_left;  // Wait states left in this access
    bit          random_waits;
    string       test_name;

    rv_core dut_i (
        .clock(clock), .reset(reset), .apb_rsp(apb_rsp), .apb_req(apb_req), .halted(halted)
    );

    always #2 clock = ~clock;  // 4 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fill_word(int k);
        return {k[7:0], ~k[7:0], 8'h5a, k[7:0] ^ 8'hc3};  // Unique per word
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                           int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                           int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(int rd, int imm20);
        return {imm20[19:0], rd[4:0], op_lui};
    endfunction

    function automatic logic [31:0] j_type(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(op_imm, f3_add_sub, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] lw(int rd, int rs1, int imm);
        return i_type(op_load, f3_word, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3_word, imm[4:0], op_store};
    endfunction

    task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    // APB slave model evaluated once per falling edge
    task automatic respond_bus();
        logic [31:0] r;
        if (apb_req.psel && !apb_req.penable) begin
            r = lcg_next();
            waits_left = random_waits ? int'(r[31:30]) : 0;  // Zero to three wait states
            apb_rsp.pready = 1'b0;
        end else if (apb_req.psel) begin
            if (waits_left == 0) begin
                check("paddr range", 32'd0, apb_req.paddr & 32'hffff_fc03);
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = mem[apb_req.paddr[9:2]];
                if (apb_req.pwrite) begin
                    mem[apb_req.paddr[9:2]] = apb_req.pwdata;  // Commits with pready
                end
            end else begin
                apb_rsp.pready = 1'b0;
                waits_left--;
            end
        end else begin
            apb_rsp.pready = 1'b0;
        end
    endtask

    task automatic step();
        @(negedge clock);
        respond_bus();
    endtask

    task automatic emit(logic [31:0] word);
        mem[emit_idx] = word;
        emit_idx++;
    endtask

    task automatic start_program(string name);
        test_name = random_waits ? {name, " with waits"} : name;
        reset = 1'b1;
        for (int k = 0; k < 256; k++) begin
            mem[k] = fill_word(k);
        end
        emit_idx = 0;
    endtask

    task automatic run_to_halt();
        int cycles;
        repeat (4) step();  // Reset held four cycles
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < 3000) begin
            step();
            cycles++;
        end
        if (!halted) begin
            $display("timeout: %s never reached ebreak", test_name);
            $display("=== FAIL ===");
            $fatal(1, "halt timeout");
        end
    endtask

    task automatic register_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] big;
        a = -7;
        b = 5;
        big = 32'h8000_0000;
        start_program("register_ops");
        emit(addi(10, 0, 256));  // Data base 0x100
        emit(addi(1, 0, -7));
        emit(addi(2, 0, 5));
        emit(u_type(3, 'h80000));
        emit(r_type(7'h00, f3_add_sub, 4, 1, 2));
        emit(sw(4, 10, 0));
        emit(r_type(7'h20, f3_add_sub, 5, 2, 1));  // sub
        emit(sw(5, 10, 4));
        emit(r_type(7'h00, f3_and, 6, 1, 2));
        emit(sw(6, 10, 8));
        emit(r_type(7'h00, f3_slt, 7, 1, 2));
        emit(sw(7, 10, 12));
        emit(r_type(7'h00, f3_slt, 8, 2, 1));
        emit(sw(8, 10, 16));
        emit(r_type(7'h00, f3_slt, 9, 2, 2));     // Equal operands
        emit(sw(9, 10, 20));
        emit(r_type(7'h20, f3_add_sub, 11, 3, 2)); // Wraps past min int
        emit(sw(11, 10, 24));
        emit(r_type(7'h00, f3_add_sub, 12, 3, 3));
        emit(sw(12, 10, 28));
        emit(32'h0010_0073);  // ebreak
        run_to_halt();
        check("add", a + b, mem[64]);
        check("sub", b - a, mem[65]);
        check("and", a & b, mem[66]);
        check("slt less", 32'd1, mem[67]);
        check("slt greater", 32'd0, mem[68]);
        check("slt equal", 32'd0, mem[69]);
        check("sub wrap", big - b, mem[70]);
        check("add wrap", big + big, mem[71]);
    endtask

    task automatic immediate_ops();
        logic [31:0] v;
        v = -100;
        start_program("immediate_ops");
        emit(addi(10, 0, 256));
        emit(addi(1, 0, -100));
        emit(addi(2, 1, -28));
        emit(sw(2, 10, 0));
        emit(i_type(op_imm, f3_slt, 3, 1, -99));
        emit(sw(3, 10, 4));
        emit(i_type(op_imm, f3_slt, 4, 1, -100));
        emit(sw(4, 10, 8));
        emit(i_type(op_imm, f3_sll, 5, 1, 4));
        emit(sw(5, 10, 12));
        emit(i_type(op_imm, f3_srl_sra, 6, 1, 3));
        emit(sw(6, 10, 16));
        emit(i_type(op_imm, f3_srl_sra, 7, 1, 'h403));  // srai
        emit(sw(7, 10, 20));
        emit(u_type(8, 'h12345));
        emit(addi(8, 8, 'h678));
        emit(sw(8, 10, 24));
        emit(addi(0, 0, 55));  // Discarded by x0
        emit(sw(0, 10, 28));
        emit(32'h0010_0073);
        run_to_halt();
        check("addi negative", v - 32'd28, mem[64]);
        check("slti true", 32'd1, mem[65]);
        check("slti equal", 32'd0, mem[66]);
        check("slli", 32'hffff_f9c0, mem[67]);   // -100 times 16
        check("srli", 32'h1fff_fff3, mem[68]);   // Zero fill from the top
        check("srai", 32'hffff_fff3, mem[69]);   // -100 / 8 rounded down is -13
        check("lui addi", 32'h1234_5000 + 32'h678, mem[70]);
        check("x0 write", 32'd0, mem[71]);
    endtask

    task automatic memory_access();
        logic [31:0] hi;
        hi = 32'habcd_e000;
        start_program("memory_access");
        emit(addi(10, 0, 256));
        emit(addi(11, 10, 32));  // Second base 0x120
        emit(addi(1, 0, 11));
        emit(addi(2, 0, -22));
        emit(u_type(3, 'habcde));
        emit(sw(1, 10, 0));
        emit(sw(2, 10, 8));
        emit(sw(3, 11, -4));
        emit(lw(4, 10, 0));
        emit(lw(5, 10, 8));
        emit(lw(6, 11, -4));
        emit(r_type(7'h00, f3_add_sub, 7, 4, 5));
        emit(r_type(7'h00, f3_add_sub, 7, 7, 6));
        emit(sw(7, 10, 12));
        emit(sw(6, 10, 16));
        emit(32'h0010_0073);
        run_to_halt();
        check("sw offset 0", 32'd11, mem[64]);
        check("untouched", fill_word(65), mem[65]);
        check("sw offset 8", -22, mem[66]);
        check("sw negative offset", hi, mem[71]);
        check("loaded sum", 32'd11 - 32'd22 + hi, mem[67]);
        check("loaded copy", hi, mem[68]);
    endtask

    task automatic branch_paths();
        start_program("branch_paths");
        emit(addi(1, 0, 0));
        emit(addi(2, 0, 5));
        emit(addi(10, 0, 256));
        emit(addi(1, 1, 1));             // Count up to 5
        emit(b_type(f3_bne, 1, 2, -4));
        emit(sw(1, 10, 0));
        emit(addi(3, 0, 0));
        emit(addi(3, 3, 2));             // Steps of 2 until not below 5
        emit(b_type(f3_blt, 3, 2, -4));
        emit(sw(3, 10, 4));
        emit(addi(4, 0, -1));
        emit(b_type(f3_beq, 1, 2, 8));   // Taken
        emit(sw(4, 10, 8));
        emit(b_type(f3_beq, 1, 3, 8));   // Not taken
        emit(sw(4, 10, 12));
        emit(b_type(f3_bge, 4, 1, 8));   // -1 >= 5 fails
        emit(sw(1, 10, 16));
        emit(b_type(f3_bge, 3, 1, 8));   // Taken
        emit(sw(4, 10, 20));
        emit(b_type(f3_bge, 1, 1, 8));   // Taken on equal operands
        emit(sw(4, 10, 24));
        emit(32'h0010_0073);
        run_to_halt();
        check("bne loop count", 32'd5, mem[64]);
        check("blt loop count", 32'd6, mem[65]);
        check("beq taken skip", fill_word(66), mem[66]);
        check("beq not taken", 32'hffff_ffff, mem[67]);
        check("bge not taken", 32'd5, mem[68]);
        check("bge taken skip", fill_word(69), mem[69]);
        check("bge equal skip", fill_word(70), mem[70]);
    endtask

    task automatic jump_links();
        start_program("jump_links");
        emit(addi(10, 0, 256));
        emit(j_type(1, 12));             // pc 4 to 16
        emit(sw(0, 10, 0));
        emit(sw(0, 10, 4));
        emit(sw(1, 10, 8));
        emit(addi(5, 0, 42));
        emit(i_type(op_jalr, f3_add_sub, 6, 5, 3));  // 45 lands at 44
        emit(sw(0, 10, 12));
        emit(sw(0, 10, 16));
        emit(sw(0, 10, 20));
        emit(sw(0, 10, 24));
        emit(sw(6, 10, 28));
        emit(j_type(0, 8));
        emit(sw(0, 10, 32));
        emit(32'h0010_0073);
        run_to_halt();
        check("jal skip 0", fill_word(64), mem[64]);
        check("jal skip 1", fill_word(65), mem[65]);
        check("jal link", 32'd4 + 32'd4, mem[66]);
        for (int k = 67; k <= 70; k++) begin
            check("jalr skip", fill_word(k), mem[k]);
        end
        check("jalr link", 32'd24 + 32'd4, mem[71]);
        check("jal x0 skip", fill_word(72), mem[72]);
    endtask

    task automatic halt_hold();
        start_program("halt_hold");
        emit(addi(10, 0, 256));
        emit(addi(1, 0, 77));
        emit(sw(1, 10, 0));
        emit(32'h0010_0073);
        emit(sw(1, 10, 4));  // Never reached
        run_to_halt();
        repeat (40) begin
            step();
            check("halted held", 32'd1, {31'b0, halted});
            check("bus idle after halt", 32'd0, {31'b0, apb_req.psel});
        end
        check("store before ebreak", 32'd77, mem[64]);
        check("store after ebreak", fill_word(65), mem[65]);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        apb_rsp = '0;
        lcg_state = 32'he3532ba4;
        waits_left = 0;
        random_waits = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            random_waits = (pass == 1);  // Second pass adds random pready delays
            register_ops();
            immediate_ops();
            memory_access();
            branch_paths();
            jump_links();
        end
        halt_hold();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    output logic [xlen-1:0] result,
    output logic            eq,
    output logic            lt
);

    logic [4:0] shamt;   // Shift amount from operand b

    assign shamt = operand_b[4:0];
    assign eq    = operand_a == operand_b;
    assign lt    = $signed(operand_a) < $signed(operand_b);  // Signed compare

    always_comb begin
        case (alu_op)
            alu_add: result = operand_a + operand_b;
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_sll: result = operand_a << shamt;
            alu_srl: result = operand_a >> shamt;
            alu_sra: result = $unsigned($signed(operand_a) >>> shamt);  // Sign fill
            alu_slt: result = {{(xlen-1){1'b0}}, lt};
            default: result = operand_a + operand_b;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_apb_master import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    output apb_req_t apb_req,
    input  apb_rsp_t apb_rsp
);

    typedef enum logic [1:0] {st_idle, st_setup, st_access} apb_state_e;

    apb_state_e      state_q;
    apb_state_e      phase;     // Bus phase of this cycle
    logic            write_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] wdata_q;

    // A request seen while idle is its own setup cycle
    assign phase = (state_q == st_idle && mem_req.valid) ? st_setup : state_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            case (phase)
                st_setup:  state_q <= st_access;
                st_access: state_q <= apb_rsp.pready ? st_idle : st_access;  // Wait states
                default:   state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (phase == st_setup) begin
            write_q <= mem_req.write;  // Held for the access phase
            addr_q  <= mem_req.addr;
            wdata_q <= mem_req.wdata;
        end
    end

    always_comb begin
        apb_req.psel    = phase != st_idle;
        apb_req.penable = phase == st_access;
        apb_req.pwrite  = (phase == st_setup) ? mem_req.write : write_q;
        apb_req.paddr   = (phase == st_setup) ? mem_req.addr : addr_q;
        apb_req.pwdata  = (phase == st_setup) ? mem_req.wdata : wdata_q;
        mem_rsp.done    = phase == st_access && apb_rsp.pready;  // One cycle pulse
        mem_rsp.rdata   = apb_rsp.prdata;
    end

endmodule

`default_nettype wire

/* verilog/rv_control.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] alu_result,
    input  logic            alu_eq,
    input  logic            alu_lt,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  mem_rsp_t        mem_rsp,
    output instr_u          instr,
    output logic [xlen-1:0] operand_a,
    output logic [xlen-1:0] operand_b,
    output logic            rd_write,
    output logic [4:0]      rd_addr,
    output logic [xlen-1:0] rd_data,
    output mem_req_t        mem_req,
    output logic            halted
);

    typedef enum logic [2:0] {st_fetch, st_decode, st_execute, st_memory, st_halt} state_e;

    state_e          state_q;
    state_e          state_d;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;   // Branch destination
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;
    logic            taken;

    assign pc_plus4  = pc_q + xlen'(4);
    assign pc_target = pc_q + imm;
    assign operand_a = (ctrl.src_a == src_a_pc) ? pc_q : rs1_q;
    assign operand_b = (ctrl.src_b == src_b_imm) ? imm : rs2_q;
    assign halted    = state_q == st_halt;  // Held until reset
    assign rd_addr   = instr.r.rd;

    always_comb begin
        case (ctrl.funct3)
            f3_beq:  taken = alu_eq;
            f3_bne:  taken = !alu_eq;
            f3_blt:  taken = alu_lt;
            f3_bge:  taken = !alu_lt;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            st_fetch: begin
                if (mem_rsp.done) begin
                    state_d = st_decode;
                end
            end
            st_decode: state_d = st_execute;   // Operands latch here
            st_execute: begin
                state_d = st_fetch;
                case (ctrl.kind)
                    kind_load, kind_store: state_d = st_memory;
                    kind_halt:             state_d = st_halt;
                    kind_branch:           pc_d = taken ? pc_target : pc_plus4;
                    kind_jal, kind_jalr:   pc_d = {alu_result[xlen-1:1], 1'b0};
                    default:               pc_d = pc_plus4;  // ALU ops and unknown
                endcase
            end
            st_memory: begin
                if (mem_rsp.done) begin
                    state_d = st_fetch;
                    pc_d    = pc_plus4;
                end
            end
            default: state_d = st_halt;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= st_fetch;
            pc_q    <= reset_pc;
            mem_req <= '0;
        end else begin
            state_q       <= state_d;
            pc_q          <= pc_d;
            mem_req.valid <= state_d == st_fetch || state_d == st_memory;  // Held through waits
            mem_req.write <= state_d == st_memory && ctrl.kind == kind_store;
            mem_req.addr  <= (state_d == st_memory) ? alu_result : pc_d;
            mem_req.wdata <= rs2_q;
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == st_fetch && mem_rsp.done) begin
            instr <= mem_rsp.rdata;
        end
        if (state_q == st_decode) begin
            // lui has immediate bits in the rs1 field, so operand a is forced to zero
            rs1_q <= (instr.u.opcode == op_lui) ? '0 : rs1_data;
            rs2_q <= rs2_data;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_load: rd_data = mem_rsp.rdata;
            wb_pc4:  rd_data = pc_plus4;       // Link value
            default: rd_data = alu_result;
        endcase
        rd_write = ctrl.reg_write && (instr.r.rd != '0)
                 && ((state_q == st_execute && ctrl.kind != kind_load)
                     || (state_q == st_memory && mem_rsp.done));
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  apb_rsp_t apb_rsp,
    output apb_req_t apb_req,
    output logic     halted
);

    instr_u          instr;       // Instruction register
    ctrl_t           ctrl;        // Decoded control word
    logic [xlen-1:0] imm;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;
    logic            alu_eq;
    logic            alu_lt;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rd_write;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rd_data;
    mem_req_t        mem_req;     // Control to bus unit
    mem_rsp_t        mem_rsp;

    rv_control control_i (
        .clock(clock), .reset(reset), .ctrl(ctrl), .imm(imm),
        .alu_result(alu_result), .alu_eq(alu_eq), .alu_lt(alu_lt),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .mem_rsp(mem_rsp),
        .instr(instr), .operand_a(operand_a), .operand_b(operand_b),
        .rd_write(rd_write), .rd_addr(rd_addr), .rd_data(rd_data),
        .mem_req(mem_req), .halted(halted)
    );

    rv_decoder decoder_i (.instr(instr), .ctrl(ctrl), .imm(imm));

    rv_alu alu_i (
        .alu_op(ctrl.alu_op), .operand_a(operand_a), .operand_b(operand_b),
        .result(alu_result), .eq(alu_eq), .lt(alu_lt)
    );

    rv_regfile regfile_i (
        .clock(clock), .reset(reset),
        .rs1_addr(instr.r.rs1), .rs2_addr(instr.r.rs2),  // Read straight from the IR
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_write(rd_write), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    rv_apb_master apb_master_i (
        .clock(clock), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

endmodule

`default_nettype wire

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  instr_u          instr,
    output ctrl_t           ctrl,
    output logic [xlen-1:0] imm
);

    always_comb begin
        ctrl = '{kind: kind_none, alu_op: alu_add, src_a: src_a_rs1, src_b: src_b_rs2,
                 wb_sel: wb_alu, reg_write: 1'b0, funct3: instr.r.funct3};
        case (instr.r.opcode)
            op_reg: begin
                ctrl.kind      = kind_alu;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct3)
                    f3_add_sub: ctrl.alu_op = instr.r.funct7[5] ? alu_sub : alu_add;
                    f3_slt:     ctrl.alu_op = alu_slt;
                    f3_and:     ctrl.alu_op = alu_and;
                    default:    ctrl.kind = kind_none;
                endcase
                if (instr.r.funct7 != 7'b0000000
                    && !(instr.r.funct7 == 7'b0100000 && instr.r.funct3 == f3_add_sub)) begin
                    ctrl.kind = kind_none;  // Only sub uses funct7
                end
            end
            op_imm: begin
                ctrl.kind      = kind_alu;
                ctrl.src_b     = src_b_imm;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct3)
                    f3_add_sub: ctrl.alu_op = alu_add;
                    f3_slt:     ctrl.alu_op = alu_slt;
                    f3_sll:     ctrl.alu_op = alu_sll;
                    f3_srl_sra: ctrl.alu_op = instr.r.funct7[5] ? alu_sra : alu_srl;
                    default:    ctrl.kind = kind_none;
                endcase
                if ((instr.r.funct3 == f3_sll && instr.r.funct7 != 7'b0000000)
                    || (instr.r.funct3 == f3_srl_sra && (instr.r.funct7 & 7'b1011111) != '0)) begin
                    ctrl.kind = kind_none;  // Bad shift encoding
                end
            end
            op_lui: begin
                ctrl.kind      = kind_alu;   // Zero plus upper immediate
                ctrl.src_b     = src_b_imm;
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                if (instr.i.funct3 == f3_word) begin
                    ctrl.kind      = kind_load;
                    ctrl.src_b     = src_b_imm;
                    ctrl.wb_sel    = wb_load;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_store: begin
                if (instr.s.funct3 == f3_word) begin
                    ctrl.kind  = kind_store;
                    ctrl.src_b = src_b_imm;
                end
            end
            op_branch: begin
                if (instr.b.funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge}) begin
                    ctrl.kind   = kind_branch;  // Flags compare rs1 with rs2
                    ctrl.alu_op = alu_sub;
                end
            end
            op_jal: begin
                ctrl.kind      = kind_jal;
                ctrl.src_a     = src_a_pc;
                ctrl.src_b     = src_b_imm;
                ctrl.wb_sel    = wb_pc4;
                ctrl.reg_write = 1'b1;
            end
            op_jalr: begin
                if (instr.i.funct3 == f3_add_sub) begin
                    ctrl.kind      = kind_jalr;
                    ctrl.src_b     = src_b_imm;
                    ctrl.wb_sel    = wb_pc4;
                    ctrl.reg_write = 1'b1;
                end
            end
            op_system: begin
                if (instr.i.imm == 12'd1 && instr.i.rs1 == '0 && instr.i.funct3 == '0
                    && instr.i.rd == '0) begin
                    ctrl.kind = kind_halt;  // ebreak
                end
            end
            default: ctrl.kind = kind_none;
        endcase
        if (ctrl.kind == kind_none) begin
            ctrl.reg_write = 1'b0;  // Unknown words only advance the PC
        end
    end

    always_comb begin
        case (instr.r.opcode)
            op_store:  imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            op_branch: imm = {{(xlen-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                              instr.b.imm4_1, 1'b0};
            op_lui:    imm = {instr.u.imm, 12'b0};
            op_jal:    imm = {{(xlen-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                              instr.j.imm10_1, 1'b0};
            default:   imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};  // I format
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;                   // Data and address width
    localparam int reg_count = 32;              // Architectural registers
    localparam logic [xlen-1:0] reset_pc = '0;  // First fetch address

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;  // ebreak only

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_bge     = 3'b101;
    localparam logic [2:0] f3_word    = 3'b010;  // lw and sw width

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_sll, alu_srl, alu_sra, alu_slt
    } alu_op_e;
    typedef enum logic {src_a_rs1, src_a_pc} src_a_e;
    typedef enum logic {src_b_rs2, src_b_imm} src_b_e;
    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_e;
    typedef enum logic [2:0] {
        kind_alu, kind_load, kind_store, kind_branch, kind_jal, kind_jalr, kind_halt, kind_none
    } kind_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;
    typedef struct packed {
        logic [6:0] imm_hi;     // Offset bits 11 to 5
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;
    typedef struct packed {
        logic       imm12;      // Sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;
    typedef struct packed {
        logic       imm20;      // Sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {  // One fetched word read per opcode
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        kind_e      kind;       // Instruction class for control
        alu_op_e    alu_op;
        src_a_e     src_a;
        src_b_e     src_b;
        wb_sel_e    wb_sel;     // Writeback source
        logic       reg_write;
        logic [2:0] funct3;     // Branch condition
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;
    typedef struct packed {
        logic            done;
        logic [xlen-1:0] rdata;
    } mem_rsp_t;
    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [xlen-1:0] paddr;
        logic [xlen-1:0] pwdata;
    } apb_req_t;
    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            rd_write,
    input  logic [4:0]      rd_addr,
    input  logic [xlen-1:0] rd_data
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;  // x0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire
